// ==== rtl/m6502_pkg.sv ====
`default_nettype none

package m6502_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;

	// Bus cycle the core is in when cpu_en arrives
	typedef enum logic [2:0] {
		ST_VEC_LO,
		ST_VEC_HI,
		ST_FETCH,
		ST_OPER_LO,
		ST_OPER_HI,
		ST_EXEC,
		ST_HALT
	} cpu_state_t;

	localparam byte_t OP_LDA_IMM = 8'ha9;
	localparam byte_t OP_LDX_IMM = 8'ha2;
	localparam byte_t OP_LDY_IMM = 8'ha0;
	localparam byte_t OP_STA_ZP = 8'h85;
	localparam byte_t OP_STA_ABS = 8'h8d;
	localparam byte_t OP_ADC_IMM = 8'h69;
	localparam byte_t OP_INX = 8'he8;
	localparam byte_t OP_DEX = 8'hca;
	localparam byte_t OP_CLC = 8'h18;
	localparam byte_t OP_SEC = 8'h38;
	localparam byte_t OP_BNE = 8'hd0;
	localparam byte_t OP_BEQ = 8'hf0;
	localparam byte_t OP_BCC = 8'h90;
	localparam byte_t OP_BCS = 8'hb0;
	localparam byte_t OP_JMP_ABS = 8'h4c;
	localparam byte_t OP_NOP = 8'hea;
	localparam byte_t OP_BRK = 8'h00; // Stops the core

	localparam addr_t RESET_VECTOR_ADDR = 16'hfffc;
	localparam addr_t PROGRAM_START = 16'h0010; // Returned by the vector decode
	localparam int RAM_WORDS_DEFAULT = 1024;

endpackage

`default_nettype wire

// ==== rtl/cpu_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface cpu_bus_if import m6502_pkg::*; ();

	addr_t addr;
	logic rw; // 1 read, 0 write
	byte_t wdata;
	byte_t rdata;

	modport master (
		output addr,
		output rw,
		output wdata,
		input rdata
	);

	modport slave (
		input addr,
		input rw,
		input wdata,
		output rdata
	);

endinterface

`default_nettype wire

// ==== rtl/clock_reset_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_reset_gen (
	input logic clk4,
	input logic n_reset,
	output logic cpu_en,
	output logic mem_en,
	output logic sys_n_reset
);

	logic [1:0] sync; // Reset release pipeline
	logic [1:0] phase;

	// Assert at once, release two clk4 edges later
	always_ff @(posedge clk4, negedge n_reset)
	begin
		if (!n_reset)
			sync <= 2'b00;
		else
			sync <= {sync[0], 1'b1};
	end

	assign sys_n_reset = sync[1];

	// Phase counter restarts with every system reset
	always_ff @(posedge clk4, negedge sys_n_reset)
	begin
		if (!sys_n_reset)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	// Memory sees the vector address on the first edge after release,
	// so the core's first strobe already finds valid read data
	assign mem_en = (phase == 2'd0);
	assign cpu_en = (phase == 2'd3);

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core import m6502_pkg::*; (
	input logic clk4,
	input logic sys_n_reset,
	input logic cpu_en,
	input logic ready,
	cpu_bus_if.master bus,
	output byte_t reg_a,
	output logic halted
);

	cpu_state_t state;
	byte_t a, x;
	byte_t ir; // Opcode latched at fetch
	byte_t oper_lo; // Low operand byte of absolute forms
	addr_t pc;
	logic z_flag, c_flag;

	logic advance;
	addr_t pc_inc;
	addr_t branch_target;
	logic branch_taken;
	logic [8:0] adc_sum;
	byte_t x_step;

	function automatic logic supported(byte_t op);
		case (op)
			OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_STA_ZP, OP_STA_ABS, OP_ADC_IMM,
			OP_INX, OP_DEX, OP_CLC, OP_SEC, OP_BNE, OP_BEQ, OP_BCC, OP_BCS,
			OP_JMP_ABS, OP_NOP:
				supported = 1'b1;
			OP_BRK:
				supported = 1'b0;
			default:
				supported = 1'b0;
		endcase
	endfunction

	assign advance = cpu_en && (ready || !bus.rw); // Ready stretches reads only
	assign pc_inc = pc + 16'd1;
	assign adc_sum = {1'b0, a} + {1'b0, bus.rdata} + {8'h00, c_flag};
	assign x_step = (ir == OP_INX) ? x + 8'd1 : x - 8'd1;
	assign branch_target = pc_inc + {{8{bus.rdata[7]}}, bus.rdata}; // Relative to next opcode

	always_comb
	begin
		case (ir)
			OP_BNE: branch_taken = !z_flag;
			OP_BEQ: branch_taken = z_flag;
			OP_BCC: branch_taken = !c_flag;
			OP_BCS: branch_taken = c_flag;
			default: branch_taken = 1'b0;
		endcase
	end

	assign reg_a = a;
	assign halted = (state == ST_HALT);

	always_ff @(posedge clk4, negedge sys_n_reset)
	begin
		if (!sys_n_reset)
		begin
			state <= ST_VEC_LO;
			bus.addr <= RESET_VECTOR_ADDR;
			bus.rw <= 1'b1;
			bus.wdata <= 8'h00;
			pc <= 16'h0000;
			ir <= 8'h00;
			oper_lo <= 8'h00;
			a <= 8'h00;
			x <= 8'h00;
			z_flag <= 1'b0;
			c_flag <= 1'b0;
		end
		else if (advance)
		begin
			case (state)
				ST_VEC_LO:
				begin
					pc[7:0] <= bus.rdata;
					bus.addr <= RESET_VECTOR_ADDR + 16'd1;
					state <= ST_VEC_HI;
				end
				ST_VEC_HI:
				begin
					pc[15:8] <= bus.rdata;
					bus.addr <= {bus.rdata, pc[7:0]};
					state <= ST_FETCH;
				end
				ST_FETCH:
				begin
					ir <= bus.rdata;
					if (supported(bus.rdata))
					begin
						pc <= pc_inc;
						bus.addr <= pc_inc;
						state <= ST_OPER_LO;
					end
					else
						state <= ST_HALT; // Bus stays on the offending opcode
				end
				ST_OPER_LO:
				begin
					// Defaults step past the operand byte
					pc <= pc_inc;
					bus.addr <= pc_inc;
					state <= ST_FETCH;
					case (ir)
						OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM:
						begin
							if (ir == OP_LDA_IMM)
								a <= bus.rdata;
							else if (ir == OP_LDX_IMM)
								x <= bus.rdata;
							z_flag <= (bus.rdata == 8'h00);
						end
						OP_ADC_IMM:
						begin
							a <= adc_sum[7:0];
							c_flag <= adc_sum[8];
							z_flag <= (adc_sum[7:0] == 8'h00);
						end
						OP_INX, OP_DEX:
						begin
							x <= x_step;
							z_flag <= (x_step == 8'h00);
							pc <= pc; // Implied, second byte was a dummy read
							bus.addr <= pc;
						end
						OP_CLC, OP_SEC, OP_NOP:
						begin
							if (ir != OP_NOP)
								c_flag <= (ir == OP_SEC);
							pc <= pc;
							bus.addr <= pc;
						end
						OP_BNE, OP_BEQ, OP_BCC, OP_BCS:
						begin
							if (branch_taken)
							begin
								pc <= branch_target;
								bus.addr <= branch_target;
							end
						end
						OP_STA_ZP:
						begin
							bus.addr <= {8'h00, bus.rdata};
							bus.rw <= 1'b0;
							bus.wdata <= a;
							state <= ST_EXEC;
						end
						OP_STA_ABS, OP_JMP_ABS:
						begin
							oper_lo <= bus.rdata;
							state <= ST_OPER_HI;
						end
						default:
						begin
							pc <= pc;
							bus.addr <= pc;
							state <= ST_HALT;
						end
					endcase
				end
				ST_OPER_HI:
				begin
					if (ir == OP_JMP_ABS)
					begin
						pc <= {bus.rdata, oper_lo};
						bus.addr <= {bus.rdata, oper_lo};
						state <= ST_FETCH;
					end
					else
					begin
						pc <= pc_inc;
						bus.addr <= {bus.rdata, oper_lo};
						bus.rw <= 1'b0;
						bus.wdata <= a;
						state <= ST_EXEC;
					end
				end
				ST_EXEC:
				begin
					bus.rw <= 1'b1; // Write done, back to next opcode
					bus.addr <= pc;
					state <= ST_FETCH;
				end
				ST_HALT:
				begin
					state <= ST_HALT;
				end
				default:
					state <= ST_HALT;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/system_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module system_memory import m6502_pkg::*; #(
	parameter int RAM_WORDS = RAM_WORDS_DEFAULT
) (
	input logic clk4,
	input logic mem_en,
	cpu_bus_if.slave bus,
	input logic load_en,
	input addr_t load_addr,
	input byte_t load_data
);

	localparam int ADDR_BITS = $clog2(RAM_WORDS);

	byte_t ram [RAM_WORDS];
	logic bus_in_ram;
	logic load_in_ram;

	assign bus_in_ram = (int'(bus.addr) < RAM_WORDS);
	assign load_in_ram = (int'(load_addr) < RAM_WORDS);

	// Loader wins over the processor and ignores the phase
	always_ff @(posedge clk4)
	begin
		if (load_en)
		begin
			if (load_in_ram)
				ram[load_addr[ADDR_BITS-1:0]] <= load_data;
		end
		else if (mem_en && !bus.rw && bus_in_ram)
			ram[bus.addr[ADDR_BITS-1:0]] <= bus.wdata;
	end

	// Read data is ready for the next cpu_en
	always_ff @(posedge clk4)
	begin
		if (mem_en)
		begin
			if (bus.addr == RESET_VECTOR_ADDR)
				bus.rdata <= PROGRAM_START[7:0];
			else if (bus.addr == RESET_VECTOR_ADDR + 16'd1)
				bus.rdata <= PROGRAM_START[15:8];
			else if (bus_in_ram)
				bus.rdata <= ram[bus.addr[ADDR_BITS-1:0]];
			else
				bus.rdata <= 8'hff; // Unmapped space
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_system import m6502_pkg::*; #(
	parameter int RAM_WORDS = RAM_WORDS_DEFAULT
) (
	input logic clk4,
	input logic n_reset,
	input logic ready,
	input logic load_en,
	input addr_t load_addr,
	input byte_t load_data,
	output addr_t addr,
	output logic rw,
	output byte_t wdata,
	output byte_t reg_a,
	output logic halted
);

	logic cpu_en;
	logic mem_en;
	logic sys_n_reset;

	cpu_bus_if bus ();

	clock_reset_gen clock_reset_gen_i (
		.clk4,
		.n_reset,
		.cpu_en,
		.mem_en,
		.sys_n_reset
	);

	cpu_core cpu_core_i (
		.clk4,
		.sys_n_reset,
		.cpu_en,
		.ready,
		.bus(bus.master),
		.reg_a,
		.halted
	);

	system_memory #(
		.RAM_WORDS(RAM_WORDS)
	) system_memory_i (
		.clk4,
		.mem_en,
		.bus(bus.slave),
		.load_en,
		.load_addr,
		.load_data
	);

	// Bus made visible at the top level
	assign addr = bus.addr;
	assign rw = bus.rw;
	assign wdata = bus.wdata;

endmodule

`default_nettype wire

// ==== verification/tb_cpu_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_system import m6502_pkg::*; ();

	localparam int RAM_WORDS = 1024; // Memory decode case relies on this depth
	localparam int MAX_CASES = 32;
	localparam int BUS_CYCLES_PER_CASE = 200;
	localparam int CLK_PERIOD = 100;

	logic clk4 = 1'b0;
	logic n_reset = 1'b0;
	logic ready = 1'b1;
	logic load_en = 1'b0;
	addr_t load_addr = 16'h0000;
	byte_t load_data = 8'h00;
	addr_t addr;
	logic rw;
	byte_t wdata;
	byte_t reg_a;
	logic halted;

	string case_name [MAX_CASES];
	int case_len [MAX_CASES];
	byte_t case_prog [MAX_CASES][16];
	int case_stress [MAX_CASES];
	byte_t exp_a [MAX_CASES];
	int exp_writes [MAX_CASES];
	addr_t exp_addr [MAX_CASES];
	byte_t exp_data [MAX_CASES];
	int num_cases = 0;
	logic cases_read = 1'b0;

	int write_count = 0;
	addr_t last_addr = 16'h0000;
	byte_t last_data = 8'h00;
	logic rw_prev = 1'b1;
	logic hold_prev = 1'b0;
	addr_t hold_addr = 16'h0000;
	logic stress_on = 1'b0;
	logic [31:0] lcg_state = 32'hd223_a5d3;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	logic case_ok;

	cpu_system #(
		.RAM_WORDS(RAM_WORDS)
	) cpu_system_i (
		.clk4,
		.n_reset,
		.ready,
		.load_en,
		.load_addr,
		.load_data,
		.addr,
		.rw,
		.wdata,
		.reg_a,
		.halted
	);

	initial
	begin
		forever #(CLK_PERIOD / 2) clk4 = ~clk4;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		lcg_next = state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Random ready, low about a third of the time
	always @(posedge clk4)
	begin
		if (stress_on)
		begin
			ready <= (lcg_state[31:16] % 16'd3) != 16'd0;
			lcg_state <= lcg_next(lcg_state);
		end
		else
			ready <= 1'b1;
	end

	// Each falling edge of rw starts one write cycle
	always @(negedge clk4)
	begin
		if (!n_reset)
		begin
			write_count <= 0;
			rw_prev <= 1'b1;
		end
		else
		begin
			rw_prev <= rw;
			if (rw_prev && !rw)
			begin
				write_count <= write_count + 1;
				last_addr <= addr;
				last_data <= wdata;
			end
		end
	end

	// A read cycle held by low ready keeps its address
	always @(negedge clk4)
	begin
		if (!n_reset)
			hold_prev <= 1'b0;
		else
		begin
			if (hold_prev && addr !== hold_addr && case_ok)
			begin
				$display("Bus address moved from %h to %h while ready was low",
					hold_addr, addr);
				case_ok = 1'b0;
			end
			hold_prev <= !ready && rw;
			hold_addr <= addr;
		end
	end

	task automatic check_byte(input string test, input string what,
		input byte_t expected, input byte_t actual);
		if (expected !== actual)
		begin
			$display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
			case_ok = 1'b0;
		end
	endtask

	task automatic check_addr(input string test, input string what,
		input addr_t expected, input addr_t actual);
		if (expected !== actual)
		begin
			$display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
			case_ok = 1'b0;
		end
	endtask

	task automatic check_count(input string test, input string what,
		input int expected, input int actual);
		if (expected != actual)
		begin
			$display("FAIL %s %s: expected %0d, actual %0d", test, what, expected, actual);
			case_ok = 1'b0;
		end
	endtask

	task automatic read_cases;
		int fd;
		int code;
		int i;
		string token;
		string rest;
		fd = $fopen("verification/cpu_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the case file verification/cpu_cases.txt");
			errors++;
			return;
		end
		while (num_cases < MAX_CASES)
		begin
			code = $fscanf(fd, "%s", token);
			if (code != 1)
				break;
			if (token.substr(0, 0) == "#")
				code = $fgets(rest, fd); // Column description
			else
			begin
				case_name[num_cases] = token;
				code = $fscanf(fd, "%d", case_len[num_cases]);
				for (i = 0; i < case_len[num_cases] && i < 16; i++)
					code = $fscanf(fd, "%h", case_prog[num_cases][i]);
				code = $fscanf(fd, "%d %h %d %h %h", case_stress[num_cases], exp_a[num_cases],
					exp_writes[num_cases], exp_addr[num_cases], exp_data[num_cases]);
				num_cases++;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_case(input int idx);
		int i;
		int waited;
		addr_t first_fetch;
		case_ok = 1'b1;
		@(posedge clk4);
		n_reset <= 1'b0;
		stress_on <= 1'b0;
		for (i = 0; i < case_len[idx]; i++)
		begin
			@(posedge clk4);
			load_en <= 1'b1;
			load_addr <= PROGRAM_START + addr_t'(i);
			load_data <= case_prog[idx][i];
		end
		@(posedge clk4);
		load_en <= 1'b0;
		repeat (2) @(posedge clk4);
		stress_on <= (case_stress[idx] != 0);
		n_reset <= 1'b1;
		waited = 0;
		// Two vector reads before the first fetch
		while ((addr == RESET_VECTOR_ADDR || addr == RESET_VECTOR_ADDR + 16'd1)
			&& waited < 4 * BUS_CYCLES_PER_CASE)
		begin
			@(negedge clk4);
			waited++;
		end
		first_fetch = addr;
		while (!halted && waited < 4 * BUS_CYCLES_PER_CASE)
		begin
			@(negedge clk4);
			waited++;
		end
		if (!halted)
		begin
			$display("Test %s did not halt within %0d bus cycles", case_name[idx],
				BUS_CYCLES_PER_CASE);
			case_ok = 1'b0;
		end
		else
		begin
			check_addr(case_name[idx], "first fetch", PROGRAM_START, first_fetch);
			check_byte(case_name[idx], "reg_a", exp_a[idx], reg_a);
			check_count(case_name[idx], "write count", exp_writes[idx], write_count);
			if (exp_writes[idx] > 0)
			begin
				check_addr(case_name[idx], "last write address", exp_addr[idx], last_addr);
				check_byte(case_name[idx], "last write data", exp_data[idx], last_data);
			end
		end
		if (case_ok)
		begin
			$display("PASS %s", case_name[idx]);
			passed++;
		end
		else
			failed++;
	endtask

	// Watchdog sized from the number of cases
	initial
	begin
		wait (cases_read);
		#(longint'(num_cases + 1) * (4 * BUS_CYCLES_PER_CASE + 40) * CLK_PERIOD);
		$display("Timeout, the run did not complete in the time allowed for %0d cases", num_cases);
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		read_cases();
		cases_read = 1'b1;
		if (num_cases == 0)
		begin
			$display("No test cases were read");
			errors++;
		end
		for (int c = 0; c < num_cases; c++)
			run_case(c);
		$display("Cases: %0d, passed: %0d, failed: %0d, other errors: %0d",
			num_cases, passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/cpu_cases.txt ====
# name len program_bytes(len of them) stress expected_reg_a writes last_addr last_data
# program bytes, reg_a, last_addr and last_data are hex; len, stress and writes are decimal
lda_sta 5 a9 42 85 80 00 0 42 1 0080 42
ldx_ldy 9 a2 07 a0 ff a9 81 85 81 00 0 81 1 0081 81
adc_clc 8 18 a9 10 69 22 85 82 00 0 32 1 0082 32
adc_sec 8 38 a9 10 69 22 85 83 00 0 33 1 0083 33
adc_ovf 12 18 a9 f0 69 20 85 84 69 01 85 85 00 0 12 2 0085 12
dex_loop 13 a9 5c a2 03 8d 00 03 ca d0 fa 85 86 00 0 5c 4 0086 5c
inx_beq 12 a2 ff e8 f0 02 85 87 a9 66 85 88 00 0 66 1 0088 66
beq_skip 9 a9 01 f0 02 a9 02 85 89 00 0 02 1 0089 02
bcc_bcs 13 18 90 02 a9 ee 38 b0 02 a9 dd 85 8a 00 0 00 1 008a 00
bcs_skip 8 18 b0 02 a9 3c 85 8b 00 0 3c 1 008b 3c
jmp_skip 11 a9 99 4c 17 00 85 8c ea 85 8d 00 0 99 1 008d 99
bad_opcode 8 a9 21 85 8e 02 85 8f 00 0 21 1 008e 21
mem_decode 15 a9 5a 8d 1c 04 a9 33 85 40 8d 00 02 85 41 00 0 33 4 0041 33
lda_sta_rdy 5 a9 42 85 80 00 1 42 1 0080 42
ldx_ldy_rdy 9 a2 07 a0 ff a9 81 85 81 00 1 81 1 0081 81
adc_sec_rdy 8 38 a9 10 69 22 85 83 00 1 33 1 0083 33
adc_ovf_rdy 12 18 a9 f0 69 20 85 84 69 01 85 85 00 1 12 2 0085 12
dex_loop_rdy 13 a9 5c a2 03 8d 00 03 ca d0 fa 85 86 00 1 5c 4 0086 5c
inx_beq_rdy 12 a2 ff e8 f0 02 85 87 a9 66 85 88 00 1 66 1 0088 66
bcc_bcs_rdy 13 18 90 02 a9 ee 38 b0 02 a9 dd 85 8a 00 1 00 1 008a 00

// ==== sources.f ====
rtl/m6502_pkg.sv
rtl/cpu_bus_if.sv
rtl/clock_reset_gen.sv
rtl/cpu_core.sv
rtl/system_memory.sv
rtl/cpu_system.sv
verification/tb_cpu_system.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --timing
TOP = tb_cpu_system
RTL_TOP = cpu_system
FILELIST = sources.f
BUILD_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
